// ==== hw/stlb_consts.svh ====
`ifndef STLB_CONSTS_SVH
`define STLB_CONSTS_SVH

// Way organisation
`define STLB_N_WAYS        4
`define STLB_WAY_BITS      2

// log2 of the longest run a way can hold
`define STLB_RUN_ORDER     6

// Address and ID widths, small pages only
`define STLB_VPN_BITS      20
`define STLB_PPN_BITS      20
`define STLB_PID_BITS      6

// Saturating reference counter
`define STLB_REF_BITS      8

// Wishbone slave data bus
`define STLB_WB_DATA_BITS  64

`endif

// ==== hw/stlb_pkg.sv ====
`include "stlb_consts.svh"

package stlb_pkg;

  typedef logic [`STLB_VPN_BITS-1:0]  vpn_t;
  typedef logic [`STLB_PPN_BITS-1:0]  ppn_t;
  typedef logic [`STLB_PID_BITS-1:0]  pid_t;
  typedef logic [`STLB_WAY_BITS-1:0]  way_t;
  typedef logic [`STLB_RUN_ORDER-1:0] run_off_t;
  // One bit wider than an offset, zero marks a free way
  typedef logic [`STLB_RUN_ORDER:0]   run_len_t;
  typedef logic [`STLB_REF_BITS-1:0]  ref_cnt_t;

  // Record in the low bits of the Wishbone write data
  typedef struct packed {
    logic valid;
    pid_t pid;
    vpn_t vpn;
    ppn_t ppn;
  } map_rec_t;

  typedef struct packed {
    pid_t     pid;
    vpn_t     base;
    run_len_t len;
  } entry_t;

  typedef entry_t [`STLB_N_WAYS-1:0] entry_arr_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_NEW,
    OP_APPEND,
    OP_DELETE
  } tbl_op_t;

  typedef struct packed {
    tbl_op_t op;
    way_t    way;
    entry_t  entry;
  } tbl_cmd_t;

  typedef struct packed {
    logic     en;
    way_t     way;
    run_off_t offset;
    ppn_t     ppn;
  } ram_wr_t;

  typedef struct packed {
    logic valid;
    pid_t pid;
    vpn_t vpn;
  } lup_req_t;

  typedef struct packed {
    logic valid;
    logic hit;
    ppn_t ppn;
  } lup_rsp_t;

  typedef struct packed {
    logic valid;
    way_t way;
  } ref_hit_t;

endpackage

// ==== hw/stlb_paddr_ram.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_paddr_ram
  import stlb_pkg::*;
#(
  parameter int WAY_ID      = 0,
  parameter int DEPTH_ORDER = `STLB_RUN_ORDER
) (
  input  logic                      aclk,
  input  ram_wr_t                   wr,
  input  logic [DEPTH_ORDER-1:0]    rd_offset,
  output logic [`STLB_PPN_BITS-1:0] rd_ppn
);

  logic [`STLB_PPN_BITS-1:0] mem [2**DEPTH_ORDER];

  // Write port, shared bus filtered by way
  always_ff @(posedge aclk) begin
    if (wr.en && (wr.way == way_t'(WAY_ID))) begin
      mem[wr.offset] <= wr.ppn;
    end
  end

  // Registered read port
  always_ff @(posedge aclk) begin
    rd_ppn <= mem[rd_offset];
  end

endmodule

// ==== hw/stlb_entry_table.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_entry_table
  import stlb_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  tbl_cmd_t   cmd,
  input  ref_hit_t   ref_hit,
  output entry_arr_t entries,
  output way_t       victim
);

  ref_cnt_t [`STLB_N_WAYS-1:0] ref_cnt;

  logic     free_found;
  way_t     free_way;
  way_t     min_way;
  ref_cnt_t min_cnt;
  logic     upd_same_way;

  // Table update takes priority over a hit on the same way
  assign upd_same_way = (cmd.op != OP_NONE) && (cmd.way == ref_hit.way);

  // --------------------
  // Entries and counters
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      entries <= '0;
      ref_cnt <= '0;
    end else begin
      // Saturating increment on lookup hit
      if (ref_hit.valid && !upd_same_way && (ref_cnt[ref_hit.way] != '1)) begin
        ref_cnt[ref_hit.way] <= ref_cnt[ref_hit.way] + 1'b1;
      end

      case (cmd.op)
        OP_NEW: begin
          entries[cmd.way] <= cmd.entry;
          ref_cnt[cmd.way] <= ref_cnt_t'(1);
        end
        OP_APPEND: begin
          entries[cmd.way].len <= entries[cmd.way].len + 1'b1;
        end
        OP_DELETE: begin
          entries[cmd.way].len <= '0;
        end
        default: begin
        end
      endcase
    end
  end

  // --------------------
  // Victim selection
  // --------------------
  always_comb begin
    free_found = 1'b0;
    free_way   = '0;
    min_way    = '0;
    min_cnt    = '1;
    // Downward scan leaves the lowest free index
    for (int i = `STLB_N_WAYS - 1; i >= 0; i--) begin
      if (entries[i].len == '0) begin
        free_found = 1'b1;
        free_way   = way_t'(i);
      end
    end
    // Smallest count, later index wins ties
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      if (ref_cnt[i] <= min_cnt) begin
        min_cnt = ref_cnt[i];
        min_way = way_t'(i);
      end
    end
  end

  assign victim = free_found ? free_way : min_way;

endmodule

// ==== hw/stlb_update_stage.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_update_stage
  import stlb_pkg::*;
(
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`STLB_WB_DATA_BITS-1:0] wb_dat,
  input  entry_arr_t                   entries,
  input  way_t                         victim,
  output logic                         wb_ack,
  output tbl_cmd_t                     cmd,
  output ram_wr_t                      ram_wr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_APPLY
  } state_t;

  state_t   state;
  map_rec_t rec;
  logic     rec_we;

  vpn_t [`STLB_N_WAYS-1:0] diff;
  logic     hit;
  way_t     hit_way;
  run_len_t hit_off;
  run_len_t hit_len;
  tbl_cmd_t cmd_n;
  ram_wr_t  ram_n;

  // Record capture, payload only
  always_ff @(posedge aclk) begin
    if ((state == ST_IDLE) && wb_cyc && wb_stb) begin
      rec    <= wb_dat[$bits(map_rec_t)-1:0];
      rec_we <= wb_we;
    end
  end

  // --------------------
  // Way match
  // --------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    hit_off = '0;
    hit_len = '0;
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      diff[i] = rec.vpn - entries[i].base;
      // Inside the run or one page past its end
      if ((entries[i].len != '0) && (rec.pid == entries[i].pid) &&
          (rec.vpn >= entries[i].base) && (diff[i] <= vpn_t'(entries[i].len))) begin
        hit     = 1'b1;
        hit_way = way_t'(i);
        hit_off = diff[i][`STLB_RUN_ORDER:0];
        hit_len = entries[i].len;
      end
    end
  end

  // Classification
  always_comb begin
    cmd_n = '0;
    ram_n = '0;
    ram_n.ppn = rec.ppn;
    if (rec_we && rec.valid && hit && (hit_off < hit_len)) begin
      // Modify
      ram_n.en     = 1'b1;
      ram_n.way    = hit_way;
      ram_n.offset = hit_off[`STLB_RUN_ORDER-1:0];
    end else if (rec_we && rec.valid && hit && !hit_len[`STLB_RUN_ORDER]) begin
      // Append, run not yet full
      ram_n.en     = 1'b1;
      ram_n.way    = hit_way;
      ram_n.offset = hit_off[`STLB_RUN_ORDER-1:0];
      cmd_n.op     = OP_APPEND;
      cmd_n.way    = hit_way;
    end else if (rec_we && rec.valid) begin
      ram_n.en        = 1'b1;
      ram_n.way       = victim;
      cmd_n.op        = OP_NEW;
      cmd_n.way       = victim;
      cmd_n.entry.pid  = rec.pid;
      cmd_n.entry.base = rec.vpn;
      cmd_n.entry.len  = run_len_t'(1);
    end else if (rec_we && hit && (hit_off < hit_len)) begin
      cmd_n.op  = OP_DELETE;
      cmd_n.way = hit_way;
    end
  end

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= ST_IDLE;
      wb_ack <= 1'b0;
      cmd    <= '0;
      ram_wr <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wb_cyc && wb_stb) begin
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          state  <= ST_APPLY;
          wb_ack <= 1'b1;
          cmd    <= cmd_n;
          ram_wr <= ram_n;
        end
        default: begin
          state     <= ST_IDLE;
          wb_ack    <= 1'b0;
          cmd.op    <= OP_NONE;
          ram_wr.en <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== hw/stlb_lookup_stage.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_lookup_stage
  import stlb_pkg::*;
(
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  lup_req_t                               req,
  input  entry_arr_t                             entries,
  input  logic [`STLB_N_WAYS-1:0][`STLB_PPN_BITS-1:0] rd_ppn,
  output logic [`STLB_N_WAYS-1:0][`STLB_RUN_ORDER-1:0] rd_offset,
  output ref_hit_t                               ref_hit,
  output lup_rsp_t                               rsp
);

  vpn_t [`STLB_N_WAYS-1:0] offset;
  logic hit;
  way_t hit_way;

  logic s1_valid;
  logic s1_hit;
  way_t s1_way;
  ppn_t sel_ppn;

  // --------------------
  // Stage 1
  // --------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      offset[i]    = req.vpn - entries[i].base;
      rd_offset[i] = offset[i][`STLB_RUN_ORDER-1:0];
      // Free ways have zero length and never match
      if ((req.pid == entries[i].pid) && (req.vpn >= entries[i].base) &&
          (offset[i] < vpn_t'(entries[i].len))) begin
        hit     = 1'b1;
        hit_way = way_t'(i);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
      s1_hit   <= 1'b0;
    end else begin
      s1_valid <= req.valid;
      s1_hit   <= req.valid && hit;
    end
  end

  always_ff @(posedge aclk) begin
    s1_way <= hit_way;
  end

  // --------------------
  // Stage 2
  // --------------------
  // RAM read data lines up with the stage 1 registers
  assign sel_ppn = s1_hit ? rd_ppn[s1_way] : '0;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rsp     <= '0;
      ref_hit <= '0;
    end else begin
      rsp.valid     <= s1_valid;
      rsp.hit       <= s1_hit;
      rsp.ppn       <= sel_ppn;
      ref_hit.valid <= s1_hit;
      ref_hit.way   <= s1_way;
    end
  end

endmodule

// ==== hw/stlb_top.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_top
  import stlb_pkg::*;
(
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`STLB_WB_DATA_BITS-1:0] wb_dat,
  output logic                          wb_ack,
  input  lup_req_t                      lup_req,
  output lup_rsp_t                      lup_rsp
);

  entry_arr_t entries;
  way_t       victim;
  tbl_cmd_t   tbl_cmd;
  ram_wr_t    ram_wr;
  ref_hit_t   ref_hit;

  logic [`STLB_N_WAYS-1:0][`STLB_RUN_ORDER-1:0] rd_offset;
  logic [`STLB_N_WAYS-1:0][`STLB_PPN_BITS-1:0]  rd_ppn;

  stlb_update_stage u_update (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_dat  (wb_dat),
    .entries (entries),
    .victim  (victim),
    .wb_ack  (wb_ack),
    .cmd     (tbl_cmd),
    .ram_wr  (ram_wr)
  );

  stlb_entry_table u_table (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cmd     (tbl_cmd),
    .ref_hit (ref_hit),
    .entries (entries),
    .victim  (victim)
  );

  stlb_lookup_stage u_lookup (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req       (lup_req),
    .entries   (entries),
    .rd_ppn    (rd_ppn),
    .rd_offset (rd_offset),
    .ref_hit   (ref_hit),
    .rsp       (lup_rsp)
  );

  // One physical page RAM per way
  for (genvar i = 0; i < `STLB_N_WAYS; i++) begin : g_way
    stlb_paddr_ram #(
      .WAY_ID      (i),
      .DEPTH_ORDER (`STLB_RUN_ORDER)
    ) u_ram (
      .aclk      (aclk),
      .wr        (ram_wr),
      .rd_offset (rd_offset[i]),
      .rd_ppn    (rd_ppn[i])
    );
  end

endmodule

// ==== tb/stlb_clkgen.sv ====
`timescale 1ns/1ps

module stlb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Reset released on a falling edge, like the stimulus
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  end

endmodule

// ==== tb/stlb_props.sv ====
`timescale 1ns/1ps

module stlb_props
  import stlb_pkg::*;
(
  input logic     aclk,
  input logic     aresetn,
  input logic     wb_cyc,
  input logic     wb_stb,
  input logic     wb_ack,
  input lup_req_t lup_req,
  input lup_rsp_t lup_rsp
);

  // Number of failed properties so far
  int fail_cnt = 0;

  // --------------------
  // Wishbone handshake
  // --------------------
  a_ack_in_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      $error("wb_ack high outside an open Wishbone cycle");
      fail_cnt++;
    end

  a_ack_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for more than one cycle");
      fail_cnt++;
    end

  // --------------------
  // Lookup latency
  // --------------------
  a_rsp_follows_req: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_req.valid |-> ##2 lup_rsp.valid)
    else begin
      $error("lookup response missing two cycles after request");
      fail_cnt++;
    end

  a_rsp_has_req: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_rsp.valid |-> $past(lup_req.valid, 2))
    else begin
      $error("lookup response without a request two cycles before");
      fail_cnt++;
    end

  a_hit_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    lup_rsp.hit |-> lup_rsp.valid)
    else begin
      $error("lookup hit flagged on an invalid response");
      fail_cnt++;
    end

endmodule

bind stlb_top stlb_props u_props (
  .aclk    (aclk),
  .aresetn (aresetn),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .lup_req (lup_req),
  .lup_rsp (lup_rsp)
);

// ==== tb/stlb_tb.sv ====
`timescale 1ns/1ps
`include "stlb_consts.svh"

module stlb_tb
  import stlb_pkg::*;
();

  localparam int CLK_PERIOD_NS = 10;
  localparam int N_WB_OPS      = 76;
  localparam int N_LOOKUPS     = 130;
  localparam int WB_OP_CYCLES  = 6;
  localparam int LOOKUP_CYCLES = 4;
  // Margin of two plus drain gaps between batches
  localparam int TIMEOUT_CYCLES =
    (N_WB_OPS * WB_OP_CYCLES + N_LOOKUPS * LOOKUP_CYCLES) * 2 + 100;
  localparam int RUN_PAGES = 2 ** `STLB_RUN_ORDER;
  localparam int REF_MAX   = (2 ** `STLB_REF_BITS) - 1;

  typedef struct packed {
    logic [31:0] due;
    logic        hit;
    ppn_t        ppn;
  } exp_t;

  logic                          aclk;
  logic                          aresetn;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [`STLB_WB_DATA_BITS-1:0] wb_dat;
  logic                          wb_ack;
  lup_req_t                      lup_req;
  lup_rsp_t                      lup_rsp;

  string       test_name = "reset";
  int          cycle_cnt = 0;
  logic [31:0] rng_state = 32'h53e2;
  vpn_t        app_base;
  exp_t        exp_q[$];
  exp_t        rsp_exp;

  // Reference model state
  pid_t m_pid  [`STLB_N_WAYS];
  vpn_t m_base [`STLB_N_WAYS];
  int   m_len  [`STLB_N_WAYS];
  int   m_ref  [`STLB_N_WAYS];
  ppn_t m_ram  [`STLB_N_WAYS][RUN_PAGES];

  stlb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (5)
  ) u_clkgen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  stlb_top UUT (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_dat  (wb_dat),
    .wb_ack  (wb_ack),
    .lup_req (lup_req),
    .lup_rsp (lup_rsp)
  );

  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] rand_next();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function automatic map_rec_t make_rec(input logic valid, input pid_t pid,
                                        input vpn_t vpn, input ppn_t ppn);
    map_rec_t r;
    r.valid = valid;
    r.pid   = pid;
    r.vpn   = vpn;
    r.ppn   = ppn;
    return r;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic void model_reset();
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      m_pid[i]  = '0;
      m_base[i] = '0;
      m_len[i]  = 0;
      m_ref[i]  = 0;
      for (int j = 0; j < RUN_PAGES; j++) begin
        m_ram[i][j] = '0;
      end
    end
  endfunction

  // Lowest free way, else smallest count with the higher index on ties
  function automatic int pick_victim();
    int min_way;
    int min_ref;
    min_way = 0;
    min_ref = REF_MAX + 1;
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      if (m_len[i] == 0) begin
        return i;
      end
    end
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      if (m_ref[i] <= min_ref) begin
        min_ref = m_ref[i];
        min_way = i;
      end
    end
    return min_way;
  endfunction

  function automatic void model_write(input map_rec_t r);
    int way;
    int off;
    int d;
    int v;
    way = -1;
    off = 0;
    // Match inside a run or one page past its end
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      d = int'(r.vpn) - int'(m_base[i]);
      if (m_len[i] != 0 && r.pid == m_pid[i] && d >= 0 && d <= m_len[i]) begin
        way = i;
        off = d;
      end
    end
    if (r.valid && way >= 0 && off < m_len[way]) begin
      m_ram[way][off] = r.ppn;
    end else if (r.valid && way >= 0 && m_len[way] < RUN_PAGES) begin
      m_ram[way][off] = r.ppn;
      m_len[way]++;
    end else if (r.valid) begin
      v = pick_victim();
      m_pid[v]    = r.pid;
      m_base[v]   = r.vpn;
      m_len[v]    = 1;
      m_ref[v]    = 1;
      m_ram[v][0] = r.ppn;
    end else if (way >= 0 && off < m_len[way]) begin
      m_len[way] = 0;
    end
  endfunction

  function automatic void model_lookup(input pid_t pid, input vpn_t vpn,
                                       output logic hit, output ppn_t ppn);
    int way;
    int off;
    int d;
    way = -1;
    off = 0;
    for (int i = 0; i < `STLB_N_WAYS; i++) begin
      d = int'(vpn) - int'(m_base[i]);
      if (pid == m_pid[i] && d >= 0 && d < m_len[i]) begin
        way = i;
        off = d;
      end
    end
    hit = (way >= 0);
    ppn = '0;
    if (hit) begin
      ppn = m_ram[way][off];
      if (m_ref[way] < REF_MAX) begin
        m_ref[way]++;
      end
    end
  endfunction

  // --------------------
  // Checking
  // --------------------
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // Responses come back in request order
  always @(negedge aclk) begin
    if (UUT.u_props.fail_cnt != 0) begin
      $display("Error: a bound assertion on stlb_top failed during %s", test_name);
      abort_run();
    end else if (aresetn && lup_rsp.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error: lookup response arrived with no request outstanding");
        abort_run();
      end else begin
        rsp_exp = exp_q.pop_front();
        check_value("latency", rsp_exp.due, 32'(cycle_cnt));
        check_value("hit", 32'(rsp_exp.hit), 32'(lup_rsp.hit));
        check_value("ppn", 32'(rsp_exp.ppn), 32'(lup_rsp.ppn));
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
    $display("Error: watchdog expired after %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  // --------------------
  // Bus drivers
  // --------------------
  task automatic wb_write(input map_rec_t rec);
    int waited;
    @(negedge aclk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b1;
    wb_dat = '0;
    wb_dat[$bits(map_rec_t)-1:0] = rec;
    waited = 0;
    while (!wb_ack && waited < 3) begin
      @(negedge aclk);
      waited++;
    end
    if (!wb_ack) begin
      $display("Error: %s got no Wishbone ack within 3 cycles", test_name);
      abort_run();
    end
    model_write(rec);
    // Hold the request through the edge that samples ack
    @(negedge aclk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic issue_lookup(input pid_t pid, input vpn_t vpn);
    exp_t e;
    @(negedge aclk);
    lup_req.valid = 1'b1;
    lup_req.pid   = pid;
    lup_req.vpn   = vpn;
    model_lookup(pid, vpn, e.hit, e.ppn);
    // Seen by the checker two falling edges later
    e.due = 32'(cycle_cnt + 2);
    exp_q.push_back(e);
  endtask

  task automatic drain_lookups();
    @(negedge aclk);
    lup_req = '0;
    repeat (4) @(negedge aclk);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic new_entry_and_hit();
    test_name = "new_entry";
    wb_write(make_rec(1'b1, 6'd5, 20'h12340, ppn_t'(rand_next())));
    issue_lookup(6'd5, 20'h12340);
    issue_lookup(6'd6, 20'h12340);
    issue_lookup(6'd5, 20'h12341);
    drain_lookups();
  endtask

  task automatic append_run();
    logic [31:0] r;
    test_name = "append_run";
    r = rand_next();
    app_base = vpn_t'({r[19:8], 8'h00});
    for (int i = 0; i < RUN_PAGES; i++) begin
      wb_write(make_rec(1'b1, 6'd7, app_base + vpn_t'(i), ppn_t'(rand_next())));
    end
    for (int i = 0; i < RUN_PAGES; i++) begin
      issue_lookup(6'd7, app_base + vpn_t'(i));
    end
    drain_lookups();
    // One past a full run opens another way
    wb_write(make_rec(1'b1, 6'd7, app_base + vpn_t'(RUN_PAGES), ppn_t'(rand_next())));
    issue_lookup(6'd7, app_base + vpn_t'(RUN_PAGES));
    issue_lookup(6'd7, app_base + vpn_t'(RUN_PAGES - 1));
    drain_lookups();
  endtask

  task automatic modify_page();
    test_name = "modify";
    wb_write(make_rec(1'b1, 6'd7, app_base + 20'd10, ppn_t'(rand_next())));
    issue_lookup(6'd7, app_base + 20'd9);
    issue_lookup(6'd7, app_base + 20'd10);
    issue_lookup(6'd7, app_base + 20'd11);
    drain_lookups();
  endtask

  task automatic delete_run();
    test_name = "delete";
    wb_write(make_rec(1'b0, 6'd7, app_base + 20'd20, '0));
    issue_lookup(6'd7, app_base);
    issue_lookup(6'd7, app_base + 20'd20);
    issue_lookup(6'd7, app_base + vpn_t'(RUN_PAGES - 1));
    issue_lookup(6'd7, app_base + vpn_t'(RUN_PAGES));
    drain_lookups();
    // Delete of a page nobody holds
    wb_write(make_rec(1'b0, 6'd9, 20'h00777, '0));
    issue_lookup(6'd5, 20'h12340);
    issue_lookup(6'd7, app_base + vpn_t'(RUN_PAGES));
    drain_lookups();
  endtask

  task automatic replacement();
    int hits [4];
    test_name = "replacement";
    hits = '{2, 1, 3, 1};
    // Free every way before the fill
    wb_write(make_rec(1'b0, 6'd5, 20'h12340, '0));
    wb_write(make_rec(1'b0, 6'd7, app_base + vpn_t'(RUN_PAGES), '0));
    for (int i = 0; i < 4; i++) begin
      wb_write(make_rec(1'b1, pid_t'(10 + i), vpn_t'(32'h50000 + i * 32'h100),
                        ppn_t'(rand_next())));
    end
    for (int i = 0; i < 4; i++) begin
      for (int h = 0; h < hits[i]; h++) begin
        issue_lookup(pid_t'(10 + i), vpn_t'(32'h50000 + i * 32'h100));
      end
    end
    drain_lookups();
    // Ways 1 and 3 tie on count, way 3 goes
    wb_write(make_rec(1'b1, 6'd14, 20'h50400, ppn_t'(rand_next())));
    for (int i = 0; i < 5; i++) begin
      issue_lookup(pid_t'(10 + i), vpn_t'(32'h50000 + i * 32'h100));
    end
    drain_lookups();
  endtask

  task automatic back_to_back_lookups();
    logic [31:0] r;
    int          sel;
    pid_t        pid;
    vpn_t        vpn;
    test_name = "back_to_back";
    for (int n = 0; n < 40; n++) begin
      r   = rand_next();
      sel = int'(r % 5);
      pid = pid_t'(10 + sel);
      vpn = vpn_t'(32'h50000 + sel * 32'h100 + r[4]);
      if (r[7]) begin
        pid = r[13:8];
      end
      issue_lookup(pid, vpn);
    end
    drain_lookups();
  endtask

  initial begin
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_dat  = '0;
    lup_req = '0;
    model_reset();
    wait (aresetn === 1'b1);

    new_entry_and_hit();
    append_run();
    modify_page();
    delete_run();
    replacement();
    back_to_back_lookups();

    repeat (4) @(negedge aclk);
    if (UUT.u_props.fail_cnt != 0) begin
      $display("Error: %0d bound assertion failures", UUT.u_props.fail_cnt);
      abort_run();
    end else if (exp_q.size() != 0) begin
      $display("Error: %0d lookup responses never arrived", exp_q.size());
      abort_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/stlb_pkg.sv
hw/stlb_paddr_ram.sv
hw/stlb_entry_table.sv
hw/stlb_update_stage.sv
hw/stlb_lookup_stage.sv
hw/stlb_top.sv
tb/stlb_clkgen.sv
tb/stlb_props.sv
tb/stlb_tb.sv
